// ==== Makefile ====
TOP = rover_nav_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f rover_nav_top.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Checks failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All checks passed" sim.log; then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== include/rover_nav_defines.svh ====
`ifndef ROVER_NAV_DEFINES_SVH
`define ROVER_NAV_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// navigation constants
////////////////////////////////////////////////////////////////////////////

// distance of the straight-ahead probe move
`define PROBE_DISTANCE 5

// rover counts as home at or inside this radius
`define REACH_RADIUS 8

// number of bearing sectors, 22.5 degrees each
`define HEADINGS 16

`endif

// ==== logic/location_capture.sv ====
`default_nettype none

module location_capture
   import rover_nav_pkg::*;
(
   input  wire logic       clock,
   input  wire logic       reset,
   input  wire logic       loc_req,
   input  wire polar_loc_t loc_data,
   output logic            loc_ack,
   output polar_loc_t      sample,
   output logic            sample_valid,
   input  wire logic       sample_take
);

   // new request seen with an empty slot
   logic accept;

   assign accept = loc_req && !loc_ack && !sample_valid;

   ////////////////////////////////////////////////////////////////////////////
   // four-phase handshake and slot flag
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         loc_ack      <= 1'b0;
         sample_valid <= 1'b0;
      end else begin
         // sequencer empties the slot
         if (sample_take) begin
            sample_valid <= 1'b0;
         end
         // ack only goes up into a free slot, so a busy sequencer stalls the sender
         if (accept) begin
            loc_ack      <= 1'b1;
            sample_valid <= 1'b1;
         end else if (loc_ack && !loc_req) begin
            // sender released req, close out the transfer
            loc_ack <= 1'b0;
         end
      end
   end

   // slot contents
   always_ff @(posedge clock) begin
      if (accept) begin
         sample <= loc_data;
      end
   end

   // sender keeps data steady until the ack comes back
   a_loc_data_stable: assert property (
      @(posedge clock) disable iff (reset)
      (loc_req && !loc_ack) |=> (!loc_req || $stable(loc_data))
   );

endmodule

`default_nettype wire

// ==== logic/move_command_port.sv ====
`default_nettype none

module move_command_port
   import rover_nav_pkg::*;
(
   input  wire logic          clock,
   input  wire logic          reset,
   input  wire logic          cmd_load,
   input  wire move_status_t  cmd,
   output logic               cmd_idle,
   output logic               mv_req,
   output move_status_t       mv_data,
   input  wire logic          mv_ack
);

   // idle, req up, waiting for ack to drop
   typedef enum logic [1:0] {
      P_IDLE,
      P_REQ,
      P_RELEASE
   } port_phase_t;

   port_phase_t phase;

   assign cmd_idle = (phase == P_IDLE);
   assign mv_req   = (phase == P_REQ);

   ////////////////////////////////////////////////////////////////////////////
   // four-phase sender
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         phase <= P_IDLE;
      end else begin
         case (phase)
            P_IDLE: begin
               if (cmd_load) begin
                  phase <= P_REQ;
               end
            end
            P_REQ: begin
               // req falls the cycle after ack is seen
               if (mv_ack) begin
                  phase <= P_RELEASE;
               end
            end
            default: begin
               if (!mv_ack) begin
                  phase <= P_IDLE;
               end
            end
         endcase
      end
   end

   // holding register for the move handed over by the sequencer
   always_ff @(posedge clock) begin
      if (cmd_load) begin
         mv_data <= cmd;
      end
   end

   a_mv_data_stable: assert property (
      @(posedge clock) disable iff (reset)
      mv_req |=> (!mv_req || $stable(mv_data))
   );

endmodule

`default_nettype wire

// ==== logic/orientation_math.sv ====
`default_nettype none

`include "rover_nav_defines.svh"

module orientation_math
   import rover_nav_pkg::*;
(
   input  wire logic       clock,
   input  wire logic       reset,
   input  wire logic       math_start,
   input  wire polar_loc_t origin_loc,
   input  wire polar_loc_t final_loc,
   output logic [3:0]      heading,
   output logic            still,
   output logic            math_done
);

   // last sector scored, and the sine offset
   localparam logic [3:0] LAST_K  = 4'(`HEADINGS - 1);
   localparam logic [3:0] QUARTER = 4'(`HEADINGS / 4);

   math_state_t state;
   // second convert cycle forms the difference
   logic        diff_phase;
   logic [3:0]  k_idx;

   // latched inputs
   polar_loc_t  org_q;
   polar_loc_t  fin_q;

   // cartesian points and their difference
   logic signed [10:0] x0;
   logic signed [10:0] y0;
   logic signed [10:0] x1;
   logic signed [10:0] y1;
   logic signed [10:0] dx;
   logic signed [10:0] dy;

   // search datapath, one multiply pair
   logic signed [18:0] term_x;
   logic signed [18:0] term_y;
   logic signed [19:0] score;
   logic signed [19:0] best_score;
   logic [3:0]         best_k;
   logic               win;
   logic               still_now;

   // r times cos of sector, arithmetic shift by 6
   function automatic logic signed [10:0] to_axis(input logic [7:0] r, input logic [3:0] k);
      logic signed [16:0] prod;
      prod = $signed({1'b0, r}) * cos_table(k);
      return prod[16:6];
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // heading score for the current sector
   ////////////////////////////////////////////////////////////////////////////

   assign term_x    = dx * cos_table(k_idx);
   assign term_y    = dy * cos_table(k_idx - QUARTER);
   assign score     = $signed({term_x[18], term_x}) + $signed({term_y[18], term_y});
   // first sector always wins, later ones only on a strictly higher score
   assign win       = (k_idx == 4'd0) || (score > best_score);
   assign still_now = (dx == 11'sd0) && (dy == 11'sd0);

   // control, 19 cycles from start to done
   always_ff @(posedge clock) begin
      if (reset) begin
         state      <= M_IDLE;
         diff_phase <= 1'b0;
         k_idx      <= 4'd0;
         math_done  <= 1'b0;
      end else begin
         math_done <= 1'b0;
         case (state)
            M_IDLE: begin
               if (math_start) begin
                  diff_phase <= 1'b0;
                  state      <= M_CONVERT;
               end
            end
            M_CONVERT: begin
               if (!diff_phase) begin
                  diff_phase <= 1'b1;
               end else begin
                  k_idx <= 4'd0;
                  state <= M_SEARCH;
               end
            end
            M_SEARCH: begin
               k_idx <= k_idx + 4'd1;
               if (k_idx == LAST_K) begin
                  math_done <= 1'b1;
                  state     <= M_DONE;
               end
            end
            default: begin
               // done pulse is out, back to idle
               state <= M_IDLE;
            end
         endcase
      end
   end

   // datapath
   always_ff @(posedge clock) begin
      case (state)
         M_IDLE: begin
            if (math_start) begin
               org_q <= origin_loc;
               fin_q <= final_loc;
            end
         end
         M_CONVERT: begin
            if (!diff_phase) begin
               x0 <= to_axis(org_q.r, org_q.theta);
               y0 <= to_axis(org_q.r, org_q.theta - QUARTER);
               x1 <= to_axis(fin_q.r, fin_q.theta);
               y1 <= to_axis(fin_q.r, fin_q.theta - QUARTER);
            end else begin
               dx <= x1 - x0;
               dy <= y1 - y0;
            end
         end
         M_SEARCH: begin
            if (win) begin
               best_score <= score;
               best_k     <= k_idx;
            end
            // last sector, publish the result
            if (k_idx == LAST_K) begin
               heading <= still_now ? 4'd0 : (win ? k_idx : best_k);
               still   <= still_now;
            end
         end
         default: begin
         end
      endcase
   end

   // sequencer must wait for done before starting again
   a_start_when_idle: assert property (
      @(posedge clock) disable iff (reset)
      math_start |-> (state == M_IDLE)
   );

endmodule

`default_nettype wire

// ==== logic/path_sequencer.sv ====
`default_nettype none

`include "rover_nav_defines.svh"

module path_sequencer
   import rover_nav_pkg::*;
(
   input  wire logic         clock,
   input  wire logic         reset,
   input  wire polar_loc_t   sample,
   input  wire logic         sample_valid,
   output logic              sample_take,
   input  wire logic [3:0]   target,
   output logic              math_start,
   output polar_loc_t        origin_loc,
   output polar_loc_t        final_loc,
   input  wire logic [3:0]   heading,
   input  wire logic         still,
   input  wire logic         math_done,
   output move_status_t      cmd,
   output logic              cmd_load,
   input  wire logic         cmd_idle
);

   localparam logic [3:0] HALF_TURN   = 4'(`HEADINGS / 2);
   localparam logic [3:0] LAST_SECTOR = 4'(`HEADINGS - 1);

   // fixed straight-ahead probe
   localparam move_status_t PROBE_MOVE = '{
      cmd:     '{angle: 5'd0, distance: 7'(`PROBE_DISTANCE)},
      probe:   1'b1,
      reached: 1'b0,
      missed:  1'b0
   };

   seq_state_t   state;
   logic         take_first;
   logic         take_second;
   logic         load_steer;

   // steering move pieces
   move_status_t steer;
   logic [3:0]   home_heading;
   logic [3:0]   sector_gap;
   logic         reached_now;
   logic         far_off;

   // first sample needs the output port free for the probe
   assign take_first  = (state == IDLE_STATE) && sample_valid && cmd_idle;
   assign take_second = (state == WAIT_FOR_NEW_LOC) && sample_valid;
   assign sample_take = take_first || take_second;
   assign load_steer  = (state == START_MOVE) && cmd_idle;

   ////////////////////////////////////////////////////////////////////////////
   // steering move from the second sample and the heading
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      // origin lies straight behind the rover's bearing sector
      home_heading = final_loc.theta + HALF_TURN;
      sector_gap   = final_loc.theta - target;
      reached_now  = final_loc.r <= 8'(`REACH_RADIUS);
      // circular distance above one sector
      far_off      = (sector_gap > 4'd1) && (sector_gap < LAST_SECTOR);

      steer.cmd.angle    = still ? 5'd0 : {1'b0, home_heading - heading};
      steer.cmd.distance = (final_loc.r > 8'd127) ? 7'd127 : final_loc.r[6:0];
      steer.probe        = 1'b0;
      steer.reached      = reached_now;
      // no heading from a rover that did not move
      steer.missed       = !reached_now && (far_off || still);
   end

   // fsm
   always_ff @(posedge clock) begin
      if (reset) begin
         state      <= IDLE_STATE;
         math_start <= 1'b0;
         cmd_load   <= 1'b0;
      end else begin
         math_start <= 1'b0;
         cmd_load   <= 1'b0;
         case (state)
            IDLE_STATE: begin
               // first of the pair, send the probe
               if (take_first) begin
                  cmd_load <= 1'b1;
                  state    <= WAIT_FOR_NEW_LOC;
               end
            end
            WAIT_FOR_NEW_LOC: begin
               if (take_second) begin
                  math_start <= 1'b1;
                  state      <= CALC_ORIENTATION;
               end
            end
            CALC_ORIENTATION: begin
               if (math_done) begin
                  state <= START_MOVE;
               end
            end
            START_MOVE: begin
               // probe may still be in flight on a slow ack
               if (load_steer) begin
                  cmd_load <= 1'b1;
                  state    <= SEND_WAIT;
               end
            end
            SEND_WAIT: begin
               // port drops idle only one cycle after the load pulse
               if (!cmd_load && cmd_idle) begin
                  state <= IDLE_STATE;
               end
            end
            default: begin
               state <= IDLE_STATE;
            end
         endcase
      end
   end

   // sample and command registers
   always_ff @(posedge clock) begin
      if (take_first) begin
         origin_loc <= sample;
         cmd        <= PROBE_MOVE;
      end
      if (take_second) begin
         final_loc <= sample;
      end
      if (load_steer) begin
         cmd <= steer;
      end
   end

   // output port must be free whenever a move is handed over
   a_load_into_idle: assert property (
      @(posedge clock) disable iff (reset)
      cmd_load |-> cmd_idle
   );

endmodule

`default_nettype wire

// ==== logic/rover_nav_pkg.sv ====
`default_nettype none

package rover_nav_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // payload types
   ////////////////////////////////////////////////////////////////////////////

   // rover position, bearing sector on top and radius below
   typedef struct packed {
      logic [3:0] theta;
      logic [7:0] r;
   } polar_loc_t;

   // turn in sectors, then straight distance
   typedef struct packed {
      logic [4:0] angle;
      logic [6:0] distance;
   } move_cmd_t;

   // move plus the flags that travel with it
   typedef struct packed {
      move_cmd_t  cmd;
      logic       probe;
      logic       reached;
      logic       missed;
   } move_status_t;

   ////////////////////////////////////////////////////////////////////////////
   // state encodings
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      IDLE_STATE,
      WAIT_FOR_NEW_LOC,
      CALC_ORIENTATION,
      START_MOVE,
      SEND_WAIT
   } seq_state_t;

   typedef enum logic [1:0] {
      M_IDLE,
      M_CONVERT,
      M_SEARCH,
      M_DONE
   } math_state_t;

   // cos of sector k, scaled by 64 and rounded
   // sine is read as cos of (k - 4) mod 16
   function automatic logic signed [7:0] cos_table(input logic [3:0] k);
      case (k)
         4'd0:    return 8'sd64;
         4'd1:    return 8'sd59;
         4'd2:    return 8'sd45;
         4'd3:    return 8'sd24;
         4'd4:    return 8'sd0;
         4'd5:    return -8'sd24;
         4'd6:    return -8'sd45;
         4'd7:    return -8'sd59;
         4'd8:    return -8'sd64;
         4'd9:    return -8'sd59;
         4'd10:   return -8'sd45;
         4'd11:   return -8'sd24;
         4'd12:   return 8'sd0;
         4'd13:   return 8'sd24;
         4'd14:   return 8'sd45;
         default: return 8'sd59;
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== logic/rover_nav_top.sv ====
`default_nettype none

module rover_nav_top
   import rover_nav_pkg::*;
(
   input  wire logic          clock,
   input  wire logic          reset,
   input  wire logic          loc_req,
   input  wire polar_loc_t    loc_data,
   output logic               loc_ack,
   input  wire logic [3:0]    target,
   output logic               mv_req,
   output move_status_t       mv_data,
   input  wire logic          mv_ack
);

   // capture to sequencer
   polar_loc_t   sample;
   logic         sample_valid;
   logic         sample_take;

   // sequencer to math
   logic         math_start;
   polar_loc_t   origin_loc;
   polar_loc_t   final_loc;
   logic [3:0]   heading;
   logic         still;
   logic         math_done;

   // sequencer to output
   move_status_t cmd;
   logic         cmd_load;
   logic         cmd_idle;

   ////////////////////////////////////////////////////////////////////////////
   // input side, processing, output side
   ////////////////////////////////////////////////////////////////////////////

   location_capture u_capture (
      .clock        (clock),
      .reset        (reset),
      .loc_req      (loc_req),
      .loc_data     (loc_data),
      .loc_ack      (loc_ack),
      .sample       (sample),
      .sample_valid (sample_valid),
      .sample_take  (sample_take)
   );

   path_sequencer u_sequencer (
      .clock        (clock),
      .reset        (reset),
      .sample       (sample),
      .sample_valid (sample_valid),
      .sample_take  (sample_take),
      .target       (target),
      .math_start   (math_start),
      .origin_loc   (origin_loc),
      .final_loc    (final_loc),
      .heading      (heading),
      .still        (still),
      .math_done    (math_done),
      .cmd          (cmd),
      .cmd_load     (cmd_load),
      .cmd_idle     (cmd_idle)
   );

   orientation_math u_math (
      .clock      (clock),
      .reset      (reset),
      .math_start (math_start),
      .origin_loc (origin_loc),
      .final_loc  (final_loc),
      .heading    (heading),
      .still      (still),
      .math_done  (math_done)
   );

   move_command_port u_port (
      .clock    (clock),
      .reset    (reset),
      .cmd_load (cmd_load),
      .cmd      (cmd),
      .cmd_idle (cmd_idle),
      .mv_req   (mv_req),
      .mv_data  (mv_data),
      .mv_ack   (mv_ack)
   );

endmodule

`default_nettype wire

// ==== rover_nav_top.f ====
+incdir+include
logic/rover_nav_pkg.sv
logic/location_capture.sv
logic/orientation_math.sv
logic/path_sequencer.sv
logic/move_command_port.sv
logic/rover_nav_top.sv
sim/tb_clock_gen.sv
sim/rover_nav_tb.sv

// ==== sim/rover_nav_tb.sv ====
`default_nettype none

`include "rover_nav_defines.svh"

module rover_nav_tb
   import rover_nav_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int RANDOM_PAIRS = 300;
   localparam int FORCED_PAIRS = 24;
   localparam int STILL_PAIRS  = 16;
   localparam int SLOW_PAIRS   = 40;
   localparam int TOTAL_PAIRS  = RANDOM_PAIRS + FORCED_PAIRS + STILL_PAIRS + SLOW_PAIRS;
   localparam int CLOCK_NS     = 8;
   localparam int WATCHDOG_NS  = TOTAL_PAIRS * 200 * CLOCK_NS;
   // probe in the port, second sample in the sequencer, next sample in the slot
   localparam int FULL_DEPTH   = 3;

   logic         clock;
   logic         reset;
   logic         loc_req;
   polar_loc_t   loc_data;
   logic         loc_ack;
   logic [3:0]   target;
   logic         mv_req;
   move_status_t mv_data;
   logic         mv_ack;

   integer       seed = 35254;
   integer       ack_seed = 35254;
   // long ack delays and back-to-back samples
   bit           ack_slow = 1'b0;
   // expected moves in delivery order
   move_status_t exp_q[$];
   int           accepted = 0;
   int           delivered = 0;
   bit           full_seen = 1'b0;

   tb_clock_gen clock_gen (
      .clock (clock),
      .reset (reset)
   );

   rover_nav_top uut (
      .clock    (clock),
      .reset    (reset),
      .loc_req  (loc_req),
      .loc_data (loc_data),
      .loc_ack  (loc_ack),
      .target   (target),
      .mv_req   (mv_req),
      .mv_data  (mv_data),
      .mv_ack   (mv_ack)
   );

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // cos of sector k times 64 and rounded
   function automatic int model_cos(input int k);
      case (k % 16)
         0:       return 64;
         1:       return 59;
         2:       return 45;
         3:       return 24;
         4:       return 0;
         5:       return -24;
         6:       return -45;
         7:       return -59;
         8:       return -64;
         9:       return -59;
         10:      return -45;
         11:      return -24;
         12:      return 0;
         13:      return 24;
         14:      return 45;
         default: return 59;
      endcase
   endfunction

   // signed shift rounds toward minus infinity
   function automatic int model_axis(input int r, input int k);
      return (r * model_cos(k)) >>> 6;
   endfunction

   function automatic void model_heading(input polar_loc_t o, input polar_loc_t f,
                                         output int heading, output bit still);
      int dx;
      int dy;
      int score;
      int best;
      // sine of k is cos of k + 12
      dx = model_axis(int'(f.r), int'(f.theta)) - model_axis(int'(o.r), int'(o.theta));
      dy = model_axis(int'(f.r), int'(f.theta) + 12) - model_axis(int'(o.r), int'(o.theta) + 12);
      best = 0;
      heading = 0;
      for (int k = 0; k < `HEADINGS; k++) begin
         score = dx * model_cos(k) + dy * model_cos(k + 12);
         // lowest sector wins a tie
         if (k == 0 || score > best) begin
            best = score;
            heading = k;
         end
      end
      still = (dx == 0) && (dy == 0);
      if (still) begin
         heading = 0;
      end
   endfunction

   function automatic move_status_t model_probe();
      move_status_t m;
      m.cmd.angle    = 5'd0;
      m.cmd.distance = 7'(`PROBE_DISTANCE);
      m.probe        = 1'b1;
      m.reached      = 1'b0;
      m.missed       = 1'b0;
      return m;
   endfunction

   function automatic move_status_t model_steer(input polar_loc_t o, input polar_loc_t f,
                                                input logic [3:0] tgt);
      move_status_t m;
      int heading;
      bit still;
      int home;
      int gap;
      bit far;
      model_heading(o, f, heading, still);
      // home lies opposite the bearing
      home = (int'(f.theta) + `HEADINGS / 2) % `HEADINGS;
      gap  = (int'(f.theta) - int'(tgt) + `HEADINGS) % `HEADINGS;
      far  = (gap > 1) && (gap < `HEADINGS - 1);
      m.cmd.angle    = still ? 5'd0 : 5'((home - heading + `HEADINGS) % `HEADINGS);
      m.cmd.distance = (f.r > 8'd127) ? 7'd127 : 7'(f.r);
      m.probe        = 1'b0;
      m.reached      = (int'(f.r) <= `REACH_RADIUS);
      m.missed       = !m.reached && (far || still);
      return m;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // random helpers and checks
   ////////////////////////////////////////////////////////////////////////////

   function automatic int rand_below(input int unsigned n);
      return int'({$random(seed)} % n);
   endfunction

   function automatic polar_loc_t random_loc();
      polar_loc_t l;
      l.theta = 4'(rand_below(16));
      l.r     = 8'(rand_below(256));
      return l;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_move(input string name, input move_cmd_t got, input move_cmd_t exp);
      if (got !== exp) begin
         stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   // probe, reached, missed as one 3-bit value
   task automatic check_flags(input string name, input move_status_t got,
                              input move_status_t exp);
      logic [2:0] got_f;
      logic [2:0] exp_f;
      got_f = {got.probe, got.reached, got.missed};
      exp_f = {exp.probe, exp.reached, exp.missed};
      if (got_f !== exp_f) begin
         stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got_f, exp_f));
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   // one four-phase transfer started on a falling edge
   task automatic send_location(input polar_loc_t loc);
      int gap;
      gap = ack_slow ? 0 : rand_below(3);
      repeat (gap) @(negedge clock);
      while (loc_ack) @(negedge clock);
      loc_data = loc;
      loc_req  = 1'b1;
      do @(negedge clock); while (!loc_ack);
      loc_req = 1'b0;
      do @(negedge clock); while (loc_ack);
   endtask

   // expected moves go in before the DUT can emit them
   task automatic send_pair(input polar_loc_t o, input polar_loc_t f);
      exp_q.push_back(model_probe());
      send_location(o);
      exp_q.push_back(model_steer(o, f, target));
      send_location(f);
   endtask

   // wait until every queued move has been taken so target may change
   task automatic drain_moves();
      while (exp_q.size() != 0) @(negedge clock);
   endtask

   initial begin : main_sequence
      polar_loc_t o;
      polar_loc_t f;
      int i;
      loc_req  = 1'b0;
      loc_data = '0;
      target   = 4'd0;
      mv_ack   = 1'b0;
      @(negedge reset);
      @(negedge clock);

      // random pairs with a new target every 50 pairs
      for (i = 0; i < RANDOM_PAIRS; i++) begin
         if (i % 50 == 0) begin
            drain_moves();
            target = 4'(rand_below(16));
         end
         send_pair(random_loc(), random_loc());
      end

      // forced radius and sector cases
      drain_moves();
      target = 4'(rand_below(16));
      for (i = 0; i < FORCED_PAIRS; i++) begin
         o = random_loc();
         f = random_loc();
         case (i % 4)
            0: f.r = 8'(rand_below(`REACH_RADIUS + 1));
            1: begin
               f.r     = 8'(`REACH_RADIUS + 1 + rand_below(255 - `REACH_RADIUS));
               f.theta = target + 4'(4 + rand_below(9));
            end
            2: begin
               // gap of 15, 0 or 1 sectors
               f.r     = 8'(`REACH_RADIUS + 1 + rand_below(255 - `REACH_RADIUS));
               f.theta = target + 4'(15 + rand_below(3));
            end
            default: begin
               f.r     = 8'(rand_below(`REACH_RADIUS + 1));
               f.theta = target + 4'(4 + rand_below(9));
            end
         endcase
         send_pair(o, f);
      end

      // rover did not move
      for (i = 0; i < STILL_PAIRS; i++) begin
         o = random_loc();
         if (i % 2 == 1) begin
            o.r = 8'(rand_below(`REACH_RADIUS + 1));
         end
         send_pair(o, o);
      end

      // slow output side stalls the input
      drain_moves();
      ack_slow = 1'b1;
      for (i = 0; i < SLOW_PAIRS; i++) begin
         send_pair(random_loc(), random_loc());
      end

      drain_moves();
      // room for a stray extra move to show up
      repeat (60) @(negedge clock);
      check_count("moves delivered", delivered, 2 * TOTAL_PAIRS);
      check_count("samples acked", accepted, 2 * TOTAL_PAIRS);
      if (!full_seen) begin
         stop_run("the pipeline never filled up during the slow ack phase");
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // output side responder
   ////////////////////////////////////////////////////////////////////////////

   initial begin : ack_responder
      int delay;
      move_status_t exp;
      forever begin
         @(negedge clock);
         if (mv_req === 1'b1) begin
            if (exp_q.size() == 0) begin
               stop_run("a move was issued with no move expected");
            end
            delay = ack_slow ? int'({$random(ack_seed)} % 41) : int'({$random(ack_seed)} % 4);
            repeat (delay) @(negedge clock);
            exp = exp_q.pop_front();
            check_move("mv_data.cmd", mv_data.cmd, exp.cmd);
            check_flags("mv_data.{probe,reached,missed}", mv_data, exp);
            mv_ack = 1'b1;
            do @(negedge clock); while (mv_req);
            delay = ack_slow ? int'({$random(ack_seed)} % 21) : int'({$random(ack_seed)} % 3);
            repeat (delay) @(negedge clock);
            mv_ack = 1'b0;
         end
      end
   end

   // samples acked minus moves delivered as seen on the DUT outputs
   initial begin : pipeline_monitor
      logic loc_ack_q;
      logic mv_req_q;
      loc_ack_q = 1'b0;
      mv_req_q  = 1'b0;
      forever begin
         @(negedge clock);
         if (loc_ack === 1'b1 && !loc_ack_q) begin
            accepted++;
         end
         if (mv_req === 1'b0 && mv_req_q) begin
            delivered++;
         end
         if (accepted - delivered > FULL_DEPTH) begin
            stop_run("a location was acked while the pipeline was full");
         end
         if (ack_slow && accepted - delivered == FULL_DEPTH) begin
            full_seen = 1'b1;
         end
         loc_ack_q = (loc_ack === 1'b1);
         mv_req_q  = (mv_req === 1'b1);
      end
   end

   // run length bound
   initial begin : watchdog
      #(WATCHDOG_NS);
      stop_run("timeout, the run did not finish in time");
   end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
   output logic clock,
   output logic reset
);

   timeunit 1ns;
   timeprecision 100ps;

   // 8 ns period
   localparam int HALF_PERIOD  = 4;
   localparam int RESET_CYCLES = 4;

   initial begin
      clock = 1'b0;
      forever #(HALF_PERIOD) clock = ~clock;
   end

   // reset over the first rising edges, released on a falling edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
   end

endmodule

`default_nettype wire
